//--- panel_pkg.sv
// ############################
// panel geometry and display-side types
// shared by the buffer, fetch and scan logic
// ############################
`default_nettype none

package panel_pkg;

    localparam int panel_width = 8;  // columns per row
    localparam int row_pairs   = 4;  // row r pairs with row r+4
    localparam int color_bits  = 4;  // bits per channel, also plane count

    typedef logic [2:0] col_t;
    typedef logic [1:0] row_pair_t;
    typedef logic [1:0] plane_t;

    typedef struct packed {
        logic [color_bits-1:0] red;
        logic [color_bits-1:0] green;
        logic [color_bits-1:0] blue;
    } pixel_t;

    // row in 5:3, column in 2:0, same as the address byte
    typedef struct packed {
        logic [2:0] row;
        col_t       col;
    } pixel_addr_t;

    typedef struct packed {
        logic red;
        logic green;
        logic blue;
    } rgb_bits_t;

    typedef struct packed {
        rgb_bits_t rgb_top;
        rgb_bits_t rgb_bottom;
        row_pair_t row_addr;
        logic      pixel_clk;
        logic      latch;
        logic      oe_n;  // active low output enable
    } hub75_t;

    typedef struct packed {
        logic      valid;
        row_pair_t row_pair;
        plane_t    plane;
        col_t      col;
    } fetch_req_t;

    typedef struct packed {
        rgb_bits_t             rgb_enable;
        logic [color_bits-1:0] plane_enable;
    } settings_t;

endpackage

`default_nettype wire

//--- link_pkg.sv
// ############################
// serial command protocol and frame buffer write types
// ############################
`default_nettype none

package link_pkg;

    import panel_pkg::*;

    // pixel: addr, hi (red nibble), lo (green, blue)
    // settings: one byte, 6:4 = b,g,r enables, 3:0 = planes
    typedef enum logic [7:0] {
        OP_PIXEL    = 8'h50,
        OP_SETTINGS = 8'h53
    } opcode_e;

    typedef enum logic [2:0] {
        st_idle,
        st_addr,
        st_data_hi,
        st_data_lo,
        st_settings
    } decode_state_e;

    typedef struct packed {
        logic        we;
        pixel_addr_t addr;
        pixel_t      data;
    } fb_write_t;

endpackage

`default_nettype wire

//--- uart_rx.sv
// ############################
// 8N1 serial receiver, one strobe per good byte
// bytes with a low stop bit are dropped
// ############################
`default_nettype none
`timescale 1ns/100ps

module uart_rx #(
    parameter int ticks_per_bit = 8
) (
    input  logic       clk_root,
    input  logic       rst_n,
    input  logic       rxd,
    output logic [7:0] rx_byte,
    output logic       rx_strobe
);

    localparam int cnt_w = $clog2(ticks_per_bit);

    typedef enum logic [1:0] {rx_idle, rx_start, rx_data, rx_stop} rx_state_e;

    rx_state_e        state;
    logic [1:0]       rxd_sync;  // two-flop synchroniser
    logic [cnt_w-1:0] tick_cnt;
    logic [2:0]       bit_cnt;
    logic             rxd_s;

    assign rxd_s = rxd_sync[1];

    always_ff @(posedge clk_root) begin
        if (!rst_n) begin
            rxd_sync  <= 2'b11;  // line idles high
            state     <= rx_idle;
            tick_cnt  <= '0;
            bit_cnt   <= '0;
            rx_strobe <= 1'b0;
        end else begin
            rxd_sync  <= {rxd_sync[0], rxd};
            rx_strobe <= 1'b0;
            case (state)
                rx_idle: begin
                    if (!rxd_s) begin
                        tick_cnt <= cnt_w'(ticks_per_bit / 2 - 1);  // to middle of start
                        state    <= rx_start;
                    end
                end
                rx_start: begin
                    if (tick_cnt != '0) begin
                        tick_cnt <= tick_cnt - 1'b1;
                    end else if (rxd_s) begin
                        state <= rx_idle;  // glitch, not a start bit
                    end else begin
                        tick_cnt <= cnt_w'(ticks_per_bit - 1);
                        bit_cnt  <= '0;
                        state    <= rx_data;
                    end
                end
                rx_data: begin
                    if (tick_cnt != '0) begin
                        tick_cnt <= tick_cnt - 1'b1;
                    end else begin
                        tick_cnt <= cnt_w'(ticks_per_bit - 1);
                        bit_cnt  <= bit_cnt + 1'b1;
                        if (bit_cnt == 3'd7)
                            state <= rx_stop;
                    end
                end
                rx_stop: begin
                    if (tick_cnt != '0) begin
                        tick_cnt <= tick_cnt - 1'b1;
                    end else begin
                        rx_strobe <= rxd_s;  // framing error gives no strobe
                        state     <= rx_idle;
                    end
                end
                default: state <= rx_idle;
            endcase
        end
    end

    // lsb first, shift in from the top
    always_ff @(posedge clk_root) begin
        if (state == rx_data && tick_cnt == '0)
            rx_byte <= {rxd_s, rx_byte[7:1]};
    end

endmodule

`default_nettype wire

//--- command_decoder.sv
// ############################
// byte stream parser, writes pixels and
// holds the colour and plane enables
// ############################
`default_nettype none
`timescale 1ns/100ps

module command_decoder import panel_pkg::*, link_pkg::*; (
    input  logic       clk_root,
    input  logic       rst_n,
    input  logic [7:0] rx_byte,
    input  logic       rx_strobe,
    output fb_write_t  fb_write,
    output settings_t  settings
);

    decode_state_e         state;
    pixel_addr_t           addr_q;
    logic [color_bits-1:0] red_q;
    logic                  wr_en;
    pixel_addr_t           wr_addr;
    pixel_t                wr_data;

    assign fb_write = '{we: wr_en, addr: wr_addr, data: wr_data};

    always_ff @(posedge clk_root) begin
        if (!rst_n) begin
            state    <= st_idle;
            wr_en    <= 1'b0;
            settings <= '1;  // everything enabled
        end else begin
            wr_en <= 1'b0;
            if (rx_strobe) begin
                case (state)
                    st_idle: begin
                        case (opcode_e'(rx_byte))
                            OP_PIXEL:    state <= st_addr;
                            OP_SETTINGS: state <= st_settings;
                            default:     state <= st_idle;  // unknown bytes ignored
                        endcase
                    end
                    st_addr:    state <= st_data_hi;
                    st_data_hi: state <= st_data_lo;
                    st_data_lo: begin
                        wr_en <= 1'b1;
                        state <= st_idle;
                    end
                    st_settings: begin
                        settings.rgb_enable.blue  <= rx_byte[6];
                        settings.rgb_enable.green <= rx_byte[5];
                        settings.rgb_enable.red   <= rx_byte[4];
                        settings.plane_enable     <= rx_byte[3:0];
                        state                     <= st_idle;
                    end
                    default: state <= st_idle;
                endcase
            end
        end
    end

    // address and pixel data collected along the way
    always_ff @(posedge clk_root) begin
        if (rx_strobe) begin
            case (state)
                st_addr:    addr_q <= pixel_addr_t'(rx_byte[5:0]);
                st_data_hi: red_q <= rx_byte[3:0];
                st_data_lo: begin
                    wr_addr <= addr_q;
                    wr_data <= '{red: red_q, green: rx_byte[7:4], blue: rx_byte[3:0]};
                end
                default: ;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- frame_buffer.sv
// ############################
// pixel memory, one write port,
// two registered read ports for top/bottom
// ############################
`default_nettype none
`timescale 1ns/100ps

module frame_buffer import panel_pkg::*, link_pkg::*; (
    input  logic        clk_root,
    input  fb_write_t   fb_write,
    input  pixel_addr_t rd_addr_top,
    input  pixel_addr_t rd_addr_bottom,
    output pixel_t      rd_top,
    output pixel_t      rd_bottom
);

    localparam int depth = 2 * row_pairs * panel_width;  // 64 pixels

    pixel_t mem [depth];

    always_ff @(posedge clk_root) begin
        if (fb_write.we)
            mem[fb_write.addr] <= fb_write.data;
        rd_top    <= mem[rd_addr_top];     // data one cycle after address
        rd_bottom <= mem[rd_addr_bottom];
    end

endmodule

`default_nettype wire

//--- row_fetch.sv
// ############################
// turns a scan request into one bit per channel
// for the top and bottom half, 2 cycles later
// ############################
`default_nettype none
`timescale 1ns/100ps

module row_fetch import panel_pkg::*; (
    input  logic        clk_root,
    input  logic        rst_n,
    input  fetch_req_t  fetch_req,
    input  settings_t   settings,
    output pixel_addr_t rd_addr_top,
    output pixel_addr_t rd_addr_bottom,
    input  pixel_t      rd_top,
    input  pixel_t      rd_bottom,
    output rgb_bits_t   col_bits_top,
    output rgb_bits_t   col_bits_bottom,
    output logic        col_valid
);

    plane_t plane_d1;  // lines up with read data
    logic   valid_d1;

    // bit p of each channel, masked by channel and plane enable
    function automatic rgb_bits_t extract_bits(pixel_t px, plane_t p, settings_t s);
        logic pe;
        pe = s.plane_enable[p];
        return '{red:   px.red[p]   & s.rgb_enable.red   & pe,
                 green: px.green[p] & s.rgb_enable.green & pe,
                 blue:  px.blue[p]  & s.rgb_enable.blue  & pe};
    endfunction

    assign rd_addr_top    = '{row: 3'(fetch_req.row_pair), col: fetch_req.col};
    assign rd_addr_bottom = '{row: 3'(fetch_req.row_pair) + 3'(row_pairs),
                              col: fetch_req.col};  // lower half of panel

    always_ff @(posedge clk_root) begin
        if (!rst_n) begin
            valid_d1  <= 1'b0;
            col_valid <= 1'b0;
        end else begin
            valid_d1  <= fetch_req.valid;
            col_valid <= valid_d1;
        end
    end

    always_ff @(posedge clk_root) begin
        plane_d1        <= fetch_req.plane;
        col_bits_top    <= extract_bits(rd_top, plane_d1, settings);
        col_bits_bottom <= extract_bits(rd_bottom, plane_d1, settings);
    end

endmodule

`default_nettype wire

//--- matrix_scan.sv
// ############################
// HUB75 scan sequencer, shift / latch / display
// with binary-coded plane times
// ############################
`default_nettype none
`timescale 1ns/100ps

module matrix_scan import panel_pkg::*; #(
    parameter int base_ticks = 8
) (
    input  logic       clk_root,
    input  logic       rst_n,
    output fetch_req_t fetch_req,
    input  rgb_bits_t  col_bits_top,
    input  rgb_bits_t  col_bits_bottom,
    input  logic       col_valid,
    output hub75_t     panel
);

    localparam int     timer_w    = $clog2(base_ticks << (color_bits - 1));
    localparam col_t   last_col   = col_t'(panel_width - 1);
    localparam plane_t last_plane = plane_t'(color_bits - 1);

    typedef enum logic [2:0] {
        sc_request, sc_wait, sc_setup, sc_clock, sc_latch, sc_enable, sc_display
    } scan_state_e;

    scan_state_e        state;
    col_t               col;
    plane_t             plane;
    row_pair_t          row_pair;
    logic               req_valid;
    logic [timer_w-1:0] timer;
    rgb_bits_t          rgb_top_q;
    rgb_bits_t          rgb_bottom_q;
    row_pair_t          row_addr_q;
    logic               pixel_clk_q;
    logic               latch_q;
    logic               oe_n_q;

    assign fetch_req = '{valid: req_valid, row_pair: row_pair, plane: plane, col: col};
    assign panel     = '{rgb_top: rgb_top_q, rgb_bottom: rgb_bottom_q, row_addr: row_addr_q,
                         pixel_clk: pixel_clk_q, latch: latch_q, oe_n: oe_n_q};

    always_ff @(posedge clk_root) begin
        if (!rst_n) begin
            state       <= sc_request;
            col         <= '0;
            plane       <= '0;
            row_pair    <= '0;
            req_valid   <= 1'b0;
            timer       <= '0;
            row_addr_q  <= '0;
            pixel_clk_q <= 1'b0;
            latch_q     <= 1'b0;
            oe_n_q      <= 1'b1;  // LEDs dark
        end else begin
            req_valid <= 1'b0;
            case (state)
                sc_request: begin
                    req_valid <= 1'b1;
                    state     <= sc_wait;
                end
                sc_wait: if (col_valid) state <= sc_setup;  // bits go to pins
                sc_setup: begin
                    pixel_clk_q <= 1'b1;  // data had one cycle of setup
                    state       <= sc_clock;
                end
                sc_clock: begin
                    pixel_clk_q <= 1'b0;
                    if (col == last_col) begin
                        state <= sc_latch;
                    end else begin
                        col   <= col + 1'b1;
                        state <= sc_request;
                    end
                end
                sc_latch: begin
                    latch_q    <= 1'b1;
                    row_addr_q <= row_pair;  // oe_n still high here
                    state      <= sc_enable;
                end
                sc_enable: begin
                    latch_q <= 1'b0;
                    oe_n_q  <= 1'b0;
                    timer   <= timer_w'((base_ticks << plane) - 1);
                    state   <= sc_display;
                end
                sc_display: begin
                    if (timer != '0) begin
                        timer <= timer - 1'b1;
                    end else begin
                        oe_n_q <= 1'b1;
                        col    <= '0;
                        state  <= sc_request;
                        if (plane == last_plane) begin
                            plane    <= '0;
                            row_pair <= row_pair + 1'b1;  // wraps after last pair
                        end else begin
                            plane <= plane + 1'b1;
                        end
                    end
                end
                default: state <= sc_request;
            endcase
        end
    end

    always_ff @(posedge clk_root) begin
        if (state == sc_wait && col_valid) begin
            rgb_top_q    <= col_bits_top;
            rgb_bottom_q <= col_bits_bottom;
        end
    end

endmodule

`default_nettype wire

//--- led_panel_top.sv
// ############################
// top level, serial commands in, HUB75 pins out
// ############################
`default_nettype none
`timescale 1ns/100ps

module led_panel_top import panel_pkg::*, link_pkg::*; #(
    parameter int ticks_per_bit = 8,
    parameter int base_ticks    = 8
) (
    input  logic   clk_root,
    input  logic   rst_n,
    input  logic   uart_rxd,
    output hub75_t panel
);

    logic [7:0]  rx_byte;
    logic        rx_strobe;
    fb_write_t   fb_write;
    settings_t   settings;
    pixel_addr_t rd_addr_top;
    pixel_addr_t rd_addr_bottom;
    pixel_t      rd_top;
    pixel_t      rd_bottom;
    fetch_req_t  fetch_req;
    rgb_bits_t   col_bits_top;
    rgb_bits_t   col_bits_bottom;
    logic        col_valid;

    uart_rx #(.ticks_per_bit(ticks_per_bit)) u_uart_rx (
        .clk_root(clk_root), .rst_n(rst_n), .rxd(uart_rxd),
        .rx_byte(rx_byte), .rx_strobe(rx_strobe)
    );

    command_decoder u_decoder (
        .clk_root(clk_root), .rst_n(rst_n), .rx_byte(rx_byte), .rx_strobe(rx_strobe),
        .fb_write(fb_write), .settings(settings)
    );

    frame_buffer u_frame_buffer (
        .clk_root(clk_root), .fb_write(fb_write),
        .rd_addr_top(rd_addr_top), .rd_addr_bottom(rd_addr_bottom),
        .rd_top(rd_top), .rd_bottom(rd_bottom)
    );

    row_fetch u_row_fetch (
        .clk_root(clk_root), .rst_n(rst_n), .fetch_req(fetch_req), .settings(settings),
        .rd_addr_top(rd_addr_top), .rd_addr_bottom(rd_addr_bottom),
        .rd_top(rd_top), .rd_bottom(rd_bottom),
        .col_bits_top(col_bits_top), .col_bits_bottom(col_bits_bottom), .col_valid(col_valid)
    );

    matrix_scan #(.base_ticks(base_ticks)) u_matrix_scan (
        .clk_root(clk_root), .rst_n(rst_n), .fetch_req(fetch_req),
        .col_bits_top(col_bits_top), .col_bits_bottom(col_bits_bottom),
        .col_valid(col_valid), .panel(panel)
    );

endmodule

`default_nettype wire

//--- tb_led_panel_chk.sv
// ############################
// bound into the scanner, checks the HUB75 pin protocol
// ############################
`default_nettype none
`timescale 1ns/100ps

module tb_led_panel_chk import panel_pkg::*; (
    input logic   clk_root,
    input logic   rst_n,
    input hub75_t panel
);

    // never latch while the LEDs are lit
    a_latch_dark: assert property (@(posedge clk_root) disable iff (!rst_n)
        !(panel.latch && !panel.oe_n))
        else $error("latch raised while oe_n is low");

    a_latch_pulse: assert property (@(posedge clk_root) disable iff (!rst_n)
        panel.latch |=> !panel.latch)
        else $error("latch high for more than one cycle");

    a_clk_pulse: assert property (@(posedge clk_root) disable iff (!rst_n)
        panel.pixel_clk |=> !panel.pixel_clk)
        else $error("pixel_clk high for more than one cycle");

    a_row_stable: assert property (@(posedge clk_root) disable iff (!rst_n)
        !panel.oe_n |=> (panel.oe_n || $stable(panel.row_addr)))  // only moves when dark
        else $error("row_addr changed while oe_n is low");

endmodule

bind matrix_scan tb_led_panel_chk u_chk (.clk_root(clk_root), .rst_n(rst_n), .panel(panel));

`default_nettype wire

//--- tb_led_panel.sv
// ############################
// testbench for the LED panel top
// random serial commands in and panel pins checked against a model
// ############################
`default_nettype none
`timescale 1ns/100ps

module tb_led_panel import panel_pkg::*, link_pkg::*; ();

    localparam int ticks_per_bit = 8;
    localparam int base_ticks    = 8;
    localparam int plane_cycles  = panel_width * 8 + 4;  // shift plus latch with some margin
    localparam int frame_cycles  = row_pairs * (color_bits * plane_cycles
                                   + base_ticks * ((1 << color_bits) - 1));
    localparam int max_bytes     = 320;
    localparam int max_frames    = 40;
    localparam longint timeout_ns = 2 * (longint'(max_bytes) * 10 * ticks_per_bit * 4
                                    + longint'(max_frames) * frame_cycles * 4);

    logic   clk_root;
    logic   rst_n;
    logic   uart_rxd;
    hub75_t panel;

    logic [11:0] model_fb [64];  // {red, green, blue} per pixel
    logic [2:0]  model_rgb_en;   // {red, green, blue}
    logic [3:0]  model_planes;
    logic        model_ready;
    logic        frame_ok;       // no command ended during this frame
    integer      seed;
    int          errors;
    int          checks;
    int          tests_run;
    int          tests_failed;
    int          mark_errors;
    int          mark_checks;
    int          frames_checked;
    int          latch_count;
    int          timing_checks;

    // monitor state
    logic [23:0] row_top;
    logic [23:0] row_bottom;
    int          col_count;
    int          oe_low_cnt;
    int          cur_plane;
    int          cur_pair;
    logic        prev_clk;
    logic        prev_latch;
    logic        prev_oe_n;

    led_panel_top #(.ticks_per_bit(ticks_per_bit), .base_ticks(base_ticks)) uut (
        .clk_root(clk_root), .rst_n(rst_n), .uart_rxd(uart_rxd), .panel(panel)
    );

    initial clk_root = 1'b0;
    always #2 clk_root = ~clk_root;

    task automatic compare_value(input string name, input logic [63:0] expected,
                                 input logic [63:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("error %s: expected %0h, actual %0h", name, expected, actual);
        end
    endtask

    // bit p of each channel gated by the channel and plane enables
    function automatic logic [2:0] plane_bits(logic [11:0] px, int plane);
        logic [2:0] raw;
        raw = {px[8 + plane], px[4 + plane], px[plane]};
        return raw & model_rgb_en & {3{model_planes[plane]}};
    endfunction

    function automatic logic [47:0] expected_row(int pair, int plane);
        logic [23:0] top;
        logic [23:0] bottom;
        top    = '0;
        bottom = '0;
        for (int c = 0; c < panel_width; c++) begin
            top    = {top[20:0], plane_bits(model_fb[pair * panel_width + c], plane)};
            bottom = {bottom[20:0],
                      plane_bits(model_fb[(pair + row_pairs) * panel_width + c], plane)};
        end
        return {top, bottom};
    endfunction

    // one pin sample per clock on the falling edge
    always @(negedge clk_root) begin
        if (!rst_n) begin
            col_count  = 0;
            oe_low_cnt = 0;
            prev_clk   = 1'b0;
            prev_latch = 1'b0;
            prev_oe_n  = 1'b1;
        end else begin
            if (panel.pixel_clk && !prev_clk) begin
                row_top    = {row_top[20:0], panel.rgb_top};
                row_bottom = {row_bottom[20:0], panel.rgb_bottom};
                col_count++;
            end
            if (panel.latch && !prev_latch) begin
                cur_plane = latch_count % color_bits;
                cur_pair  = (latch_count / color_bits) % row_pairs;
                compare_value("columns_per_latch", panel_width, col_count);
                if (model_ready && frame_ok)
                    compare_value($sformatf("row_p%0d_pl%0d", cur_pair, cur_plane),
                                  expected_row(cur_pair, cur_plane), {row_top, row_bottom});
                if (latch_count % (color_bits * row_pairs) == color_bits * row_pairs - 1) begin
                    if (model_ready && frame_ok)
                        frames_checked++;
                    frame_ok = 1'b1;  // next frame starts clean
                end
                col_count = 0;
                latch_count++;
            end
            if (!panel.oe_n) begin
                oe_low_cnt++;
                compare_value("row_addr", cur_pair, panel.row_addr);
            end else if (!prev_oe_n) begin
                compare_value("oe_n_low_cycles", base_ticks << cur_plane, oe_low_cnt);
                timing_checks++;
                oe_low_cnt = 0;
            end
            prev_clk   = panel.pixel_clk;
            prev_latch = panel.latch;
            prev_oe_n  = panel.oe_n;
        end
    end

    // 8N1 frame with the lsb first
    task automatic send_byte(input logic [7:0] value);
        logic [9:0] bits;
        int         i;
        bits = {1'b1, value, 1'b0};
        for (i = 0; i < 10; i++) begin
            @(posedge clk_root);
            #1 uart_rxd = bits[i];
            repeat (ticks_per_bit - 1) @(posedge clk_root);
        end
    endtask

    task automatic end_command();
        frame_ok = 1'b0;  // rows latched from here on may mix old and new data
        repeat (ticks_per_bit) @(posedge clk_root);  // idle bit so the write lands
    endtask

    task automatic send_pixel(input logic [5:0] addr, input logic [11:0] value);
        logic [3:0] upper;
        upper = 4'($random(seed));  // ignored nibble
        send_byte(OP_PIXEL);
        send_byte({2'b00, addr});
        send_byte({upper, value[11:8]});
        send_byte(value[7:0]);
        end_command();
        model_fb[addr] = value;
    endtask

    task automatic send_settings(input logic [7:0] value);
        send_byte(OP_SETTINGS);
        send_byte(value);
        end_command();
        model_rgb_en = {value[4], value[5], value[6]};
        model_planes = value[3:0];
    endtask

    task automatic wait_frames(input int n);
        int target;
        target = frames_checked + n;
        while (frames_checked < target)
            @(negedge clk_root);
    endtask

    task automatic report_test(input string name);
        tests_run++;
        if (errors != mark_errors)
            tests_failed++;
        $display("test %s: %0d checks, %0d errors", name, checks - mark_checks,
                 errors - mark_errors);
        mark_errors = errors;
        mark_checks = checks;
    endtask

    initial begin
        #(timeout_ns);
        $display("timeout: run did not finish within %0d ns", timeout_ns);
        $display("ERRORS FOUND");
        $finish;
    end

    initial begin
        int         i;
        int         n_junk;
        int         dark_low;
        int         t0;
        logic [7:0] junk;
        seed           = 62391;
        uart_rxd       = 1'b1;
        rst_n          = 1'b0;
        errors         = 0;
        checks         = 0;
        tests_run      = 0;
        tests_failed   = 0;
        mark_errors    = 0;
        mark_checks    = 0;
        frames_checked = 0;
        latch_count    = 0;
        timing_checks  = 0;
        model_rgb_en   = 3'b111;
        model_planes   = 4'hf;
        model_ready    = 1'b0;
        frame_ok       = 1'b0;
        dark_low       = 0;

        // reset state then dark until the first latch
        repeat (9) @(posedge clk_root);
        @(negedge clk_root);
        compare_value("reset_oe_n", 1, panel.oe_n);
        compare_value("reset_latch", 0, panel.latch);
        compare_value("reset_pixel_clk", 0, panel.pixel_clk);
        @(posedge clk_root);
        #1 rst_n = 1'b1;
        @(negedge clk_root);
        while (!panel.latch) begin
            if (!panel.oe_n)
                dark_low++;
            @(negedge clk_root);
        end
        compare_value("oe_n_low_before_latch", 0, dark_low);
        report_test("reset_state");

        for (i = 0; i < 64; i++)
            send_pixel(6'(i), 12'($random(seed)));
        model_ready = 1'b1;
        wait_frames(2);
        report_test("full_frame");

        t0 = timing_checks;
        wait_frames(1);
        compare_value("plane_timing_seen", 1, (timing_checks - t0) >= color_bits * row_pairs);
        report_test("plane_timing");

        for (i = 0; i < 4; i++) begin
            send_settings({1'b0, 7'($random(seed))});
            wait_frames(1);
        end
        send_settings(8'h7f);
        wait_frames(1);
        report_test("settings");

        for (i = 0; i < 6; i++) begin
            n_junk = 1 + ($random(seed) & 1);
            repeat (n_junk) begin
                junk = 8'($random(seed));
                if (junk == OP_PIXEL || junk == OP_SETTINGS)
                    junk = junk ^ 8'h80;  // keep it off the opcode list
                send_byte(junk);
            end
            send_pixel(6'($random(seed)), 12'($random(seed)));
            wait_frames(1);
        end
        report_test("robustness");

        $display("tests %0d, failed %0d, checks %0d, errors %0d", tests_run, tests_failed,
                 checks, errors);
        if (errors == 0)
            $display("NO ERRORS");
        else
            $display("ERRORS FOUND");
        $finish;
    end

endmodule

`default_nettype wire

//--- tb.f
panel_pkg.sv
link_pkg.sv
uart_rx.sv
command_decoder.sv
frame_buffer.sv
row_fetch.sv
matrix_scan.sv
led_panel_top.sv
tb_led_panel_chk.sv
tb_led_panel.sv

//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = tb_led_panel
RTL_TOP  = led_panel_top
FILELIST = tb.f
LOG      = sim.log
OBJ_DIR  = obj_dir
RTL_SRCS = $(filter-out tb_%.sv,$(shell cat $(FILELIST)))

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --Mdir $(OBJ_DIR) --top-module $(TOP) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^NO ERRORS$$" $(LOG) && echo "simulation passed" || \
		(echo "simulation failed"; exit 1)

lint:
	$(TOOL) --lint-only -Wall --top-module $(RTL_TOP) $(RTL_SRCS)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
